//--- logic/uart_frame_pkg.sv
/*
 * Shared constants and types of the "&&...&&" serial string link.
 * Content characters must never be "&" because no escaping exists.
 * MAX_CHARS sizes frame_t; LEN_W must hold 0 to MAX_CHARS.
 */
package uart_frame_pkg;

	// longest string carried by one frame
	localparam int MAX_CHARS = 16;

	// length field, 0 to MAX_CHARS inclusive
	localparam int LEN_W = 5;

	typedef logic [7:0] char_t;

	// delimiter sent twice before and twice after the content
	localparam char_t FRAME_MARK = 8'h26;

	// chars[0] is the first character on the line
	typedef struct packed {
		logic [LEN_W-1:0]      len;
		char_t [MAX_CHARS-1:0] chars;
	} frame_t;

	// one received byte, stop_err set when the stop bit was low
	typedef struct packed {
		logic  stop_err;
		char_t data;
	} rx_byte_t;

endpackage

//--- logic/uart_tx_serializer.sv
/*
 * 8N2 UART transmitter, LSB first, line high when idle.
 * ser_req is only legal while idle; ser_done follows the second stop bit.
 */
module uart_tx_serializer #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_frame_pkg::char_t ser_data,
	input  logic                  ser_req,
	output logic                  uart_tx,
	output logic                  ser_done
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	// start bit is index 0, second stop bit is index 10
	localparam logic [3:0] LAST_BIT = 4'd10;

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	logic [9:0]       shift_q;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			uart_tx  <= 1'b1;
			ser_done <= 1'b0;
		end else begin
			ser_done <= 1'b0;
			if (!busy) begin
				if (ser_req) begin
					// start bit goes out on the next clock
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
					uart_tx <= 1'b0;
				end
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == LAST_BIT) begin
					busy     <= 1'b0;
					ser_done <= 1'b1;
					uart_tx  <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					uart_tx <= shift_q[0];
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits then two stop bits, refilled with ones
	always_ff @(posedge sys_clk) begin
		if (!busy && ser_req) begin
			shift_q <= {2'b11, ser_data};
		end else if (busy && bit_end) begin
			shift_q <= {1'b1, shift_q[9:1]};
		end
	end

	// the framer waits for ser_done before it asks again
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		ser_req |-> !busy);

endmodule

//--- logic/uart_rx_sampler.sv
/*
 * 8N1 UART receiver with a two-flop synchronizer on uart_rx.
 * Bits are sampled mid-period; needs CLKS_PER_BIT of at least 4.
 * No back-pressure, each byte is a single-cycle strobe.
 */
module uart_rx_sampler #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  logic                     uart_rx,
	output uart_frame_pkg::rx_byte_t rx_byte,
	output logic                     rx_byte_vld
);
	import uart_frame_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam int HALF  = CLKS_PER_BIT / 2;

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	state_t           state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	char_t            shift_q;
	logic             half_hit;
	logic             full_hit;

	assign half_hit = (clk_cnt == CNT_W'(HALF - 1));
	assign full_hit = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= S_IDLE;
			clk_cnt     <= '0;
			bit_idx     <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			clk_cnt     <= clk_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync) begin
						state <= S_START;
					end
				end
				S_START: begin
					// recheck at mid start bit, a high line was a glitch
					if (half_hit) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? S_IDLE : S_DATA;
					end
				end
				S_DATA: begin
					if (full_hit) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end
				end
				S_STOP: begin
					if (full_hit) begin
						clk_cnt     <= '0;
						rx_byte_vld <= 1'b1;
						state       <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && full_hit) begin
			shift_q <= {rx_sync, shift_q[7:1]};
		end
		if (state == S_STOP && full_hit) begin
			rx_byte.data     <= shift_q;
			rx_byte.stop_err <= !rx_sync;
		end
	end

	// a byte takes ten bit periods, so strobes can never touch
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_byte_vld |=> !rx_byte_vld);

endmodule

//--- logic/tx_framer.sv
/*
 * Sends "&&", up to MAX_CHARS content bytes, then "&&" through the serializer.
 * The frame is captured on the accepted request; longer lengths are clamped.
 * A request while busy is dropped, nothing is queued.
 */
module tx_framer (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  uart_frame_pkg::frame_t tx_frame,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,
	output uart_frame_pkg::char_t  ser_data,
	output logic                   ser_req,
	input  logic                   ser_done
);
	import uart_frame_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_MARK1, S_MARK2, S_BODY, S_MARK3, S_MARK4, S_DONE
	} state_t;

	state_t           state;
	frame_t           frame_q;
	logic [LEN_W-1:0] idx;
	logic [LEN_W-1:0] len_in;
	logic             accept;

	assign tx_busy = (state != S_IDLE) && (state != S_DONE);
	assign accept  = tx_req && !tx_busy;
	assign len_in  = (tx_frame.len > LEN_W'(MAX_CHARS)) ? LEN_W'(MAX_CHARS) : tx_frame.len;

	// host may change tx_frame once the request is taken
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			frame_q.len   <= len_in;
			frame_q.chars <= tx_frame.chars;
		end
	end

	// each state holds the byte in flight, ser_done moves on
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			idx      <= '0;
			ser_req  <= 1'b0;
			ser_data <= '0;
			tx_done  <= 1'b0;
		end else begin
			ser_req <= 1'b0;
			tx_done <= 1'b0;
			case (state)
				S_IDLE, S_DONE: begin
					if (accept) begin
						state    <= S_MARK1;
						ser_req  <= 1'b1;
						ser_data <= FRAME_MARK;
					end else begin
						state <= S_IDLE;
					end
				end
				S_MARK1: begin
					if (ser_done) begin
						state    <= S_MARK2;
						ser_req  <= 1'b1;
						ser_data <= FRAME_MARK;
					end
				end
				S_MARK2: begin
					if (ser_done) begin
						ser_req <= 1'b1;
						if (frame_q.len == '0) begin
							// empty string gives "&&&&"
							state    <= S_MARK3;
							ser_data <= FRAME_MARK;
						end else begin
							state    <= S_BODY;
							ser_data <= frame_q.chars[0];
							idx      <= LEN_W'(1);
						end
					end
				end
				S_BODY: begin
					if (ser_done) begin
						ser_req <= 1'b1;
						if (idx == frame_q.len) begin
							state    <= S_MARK3;
							ser_data <= FRAME_MARK;
						end else begin
							ser_data <= frame_q.chars[idx];
							idx      <= idx + 1'b1;
						end
					end
				end
				S_MARK3: begin
					if (ser_done) begin
						state    <= S_MARK4;
						ser_req  <= 1'b1;
						ser_data <= FRAME_MARK;
					end
				end
				S_MARK4: begin
					if (ser_done) begin
						state   <= S_DONE;
						tx_done <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// tx_done never fires from idle
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> (state != S_IDLE));

endmodule

//--- logic/rx_deframer.sv
/*
 * Finds "&&content&&" in the received byte stream.
 * An "&" inside content is taken as the closing mark.
 * Stop errors, a bad closing mark or too much content drop the frame.
 */
module rx_deframer (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  uart_frame_pkg::rx_byte_t rx_byte,
	input  logic                     rx_byte_vld,
	output uart_frame_pkg::frame_t   rx_frame,
	output logic                     rx_busy,
	output logic                     rx_done
);
	import uart_frame_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_MARK2, S_BODY, S_CLOSE} state_t;

	state_t                state;
	logic [LEN_W-1:0]      cnt;
	char_t [MAX_CHARS-1:0] char_buf;
	logic                  good_byte;
	logic                  is_mark;
	logic                  wr_en;
	logic                  finish;

	assign good_byte = rx_byte_vld && !rx_byte.stop_err;
	assign is_mark   = (rx_byte.data == FRAME_MARK);
	assign wr_en     = good_byte && (state == S_BODY) && !is_mark &&
		(cnt < LEN_W'(MAX_CHARS));
	assign finish    = good_byte && (state == S_CLOSE) && is_mark;
	assign rx_busy   = (state != S_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else if (rx_byte_vld) begin
			if (rx_byte.stop_err) begin
				state <= S_IDLE;
			end else begin
				case (state)
					S_IDLE: begin
						if (is_mark) begin
							state <= S_MARK2;
						end
					end
					S_MARK2: begin
						cnt   <= '0;
						state <= is_mark ? S_BODY : S_IDLE;
					end
					S_BODY: begin
						if (is_mark) begin
							state <= S_CLOSE;
						end else if (wr_en) begin
							cnt <= cnt + 1'b1;
						end else begin
							// one character too many
							state <= S_IDLE;
						end
					end
					// finished or discarded, back to hunting
					S_CLOSE: state <= S_IDLE;
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			char_buf[cnt] <= rx_byte.data;
		end
	end

	// result held until the next good frame
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_frame <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= finish;
			if (finish) begin
				rx_frame.len <= cnt;
				for (int i = 0; i < MAX_CHARS; i++) begin
					// slots past the length read as zero
					rx_frame.chars[i] <= (i < cnt) ? char_buf[i] : '0;
				end
			end
		end
	end

	// stored length never exceeds the buffer
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cnt <= LEN_W'(MAX_CHARS));

endmodule

//--- logic/uart_frame_link.sv
/*
 * Serial string link, "&&content&&" over an 8-bit LSB-first UART.
 * Transmit uses two stop bits, receive checks one.
 * CLKS_PER_BIT is sys_clk cycles per bit, 868 suits 100 MHz at 115200.
 */
module uart_frame_link #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,

	input  uart_frame_pkg::frame_t tx_frame,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,

	output uart_frame_pkg::frame_t rx_frame,
	output logic                   rx_busy,
	output logic                   rx_done,

	input  logic                   uart_rx,
	output logic                   uart_tx
);
	import uart_frame_pkg::*;

	// transmit path
	char_t    ser_data;
	logic     ser_req;
	logic     ser_done;

	// receive path
	rx_byte_t rx_byte;
	logic     rx_byte_vld;

	tx_framer i_tx_framer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.ser_data  (ser_data),
		.ser_req   (ser_req),
		.ser_done  (ser_done)
	);

	uart_tx_serializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_tx_serializer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.ser_data  (ser_data),
		.ser_req   (ser_req),
		.uart_tx   (uart_tx),
		.ser_done  (ser_done)
	);

	uart_rx_sampler #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_rx_sampler (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.uart_rx     (uart_rx),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld)
	);

	rx_deframer i_rx_deframer (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_frame    (rx_frame),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done)
	);

endmodule

//--- testbench/uart_frame_model.svh
/*
 * Testbench-side UART model, included inside the testbench module body.
 * Uses sys_clk, uart_tx, drv_line and CLKS_PER_BIT of the including module.
 * Driver sends 8 data bits LSB first plus one idle bit after the stop bit.
 */
`ifndef UART_FRAME_MODEL_SVH
`define UART_FRAME_MODEL_SVH

logic [31:0] rng_state = 32'd79;

function logic [31:0] xorshift32();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// printable, never the frame mark
function char_t rand_char();
	char_t c;
	c = 8'h20 + 8'(xorshift32() % 95);
	if (c == FRAME_MARK)
		c = 8'h2b;
	return c;
endfunction

// slots past len stay random in the sent frame, zero in the expected one
task build_frame(input int len, output frame_t to_send, output frame_t expect_f);
	int i;
	to_send      = '0;
	expect_f     = '0;
	to_send.len  = LEN_W'(len);
	expect_f.len = LEN_W'(len);
	for (i = 0; i < MAX_CHARS; i++) begin
		to_send.chars[i] = rand_char();
		if (i < len)
			expect_f.chars[i] = to_send.chars[i];
	end
endtask

// start, data, stop as given, then one high bit so a low stop still leaves an edge
task send_byte(input char_t data, input logic stop_bit);
	logic [10:0] bits;
	int          i;
	bits = {1'b1, stop_bit, data, 1'b0};
	@(posedge sys_clk);
	#1;
	for (i = 0; i < 11; i++) begin
		drv_line = bits[i];
		repeat (CLKS_PER_BIT) @(posedge sys_clk);
		#1;
	end
endtask

// decodes one byte from uart_tx, returns in the middle of the second stop bit
task read_tx_byte(output char_t data);
	int n;
	int i;
	n = 0;
	@(negedge sys_clk);
	while (uart_tx !== 1'b0 && n < TIMEOUT_CLKS) begin
		@(negedge sys_clk);
		n++;
	end
	if (uart_tx !== 1'b0)
		report_failure($sformatf("timeout at %0t waiting for a start bit on uart_tx", $time));
	repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
	check_level(uart_tx, 1'b0, "uart_tx start bit");
	for (i = 0; i < 8; i++) begin
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		data[i] = uart_tx;
	end
	repeat (2) begin
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		check_level(uart_tx, 1'b1, "uart_tx stop bit");
	end
endtask

`endif

//--- testbench/tb_uart_frame_link.sv
/*
 * Random loopback and driven-line test of the serial string link.
 * CLKS_PER_BIT is 8 here to keep runs short.
 * Stops at the first mismatch or missing event.
 */
module tb_uart_frame_link;
	import uart_frame_pkg::*;

	localparam int CLKS_PER_BIT = 8;
	localparam int TIMEOUT_CLKS = 40 * 11 * CLKS_PER_BIT;
	localparam int N_FRAMES     = 30;

	logic   sys_clk;
	logic   sys_rst_n;
	frame_t tx_frame;
	logic   tx_req;
	logic   tx_busy;
	logic   tx_done;
	frame_t rx_frame;
	logic   rx_busy;
	logic   rx_done;
	logic   uart_tx;
	logic   uart_rx_in;
	logic   drv_line;
	logic   loopback;

	int tx_done_cnt = 0;
	int rx_done_cnt = 0;
	int tx_expect   = 0;
	int rx_expect   = 0;
	int err_cnt     = 0;

	// loopback feeds the DUT its own line, otherwise the model drives it
	assign uart_rx_in = loopback ? uart_tx : drv_line;

	uart_frame_link #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_frame  (rx_frame),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_rx   (uart_rx_in),
		.uart_tx   (uart_tx)
	);

	`include "uart_frame_model.svh"

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	always @(negedge sys_clk) begin
		if (tx_done)
			tx_done_cnt++;
		if (rx_done)
			rx_done_cnt++;
	end

	task report_failure(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task check_char(input char_t got, input char_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task check_frame(input frame_t got, input frame_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task check_count(input int got, input int exp, input string what);
		if (got != exp)
			report_failure($sformatf("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	task wait_done(input bit rx_side, input int target, input string what);
		int n;
		int cnt;
		n   = 0;
		cnt = rx_side ? rx_done_cnt : tx_done_cnt;
		while (cnt < target && n < TIMEOUT_CLKS) begin
			@(posedge sys_clk);
			n++;
			cnt = rx_side ? rx_done_cnt : tx_done_cnt;
		end
		if (cnt < target)
			report_failure($sformatf("timeout at %0t waiting for %s", $time, what));
	endtask

	task start_tx(input frame_t f);
		@(posedge sys_clk);
		#1;
		tx_frame = f;
		tx_req   = 1'b1;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
	endtask

	task expect_line_frame(input frame_t exp);
		char_t c;
		int    i;
		for (i = 0; i < exp.len + 4; i++) begin
			read_tx_byte(c);
			if (i < 2 || i >= exp.len + 2)
				check_char(c, FRAME_MARK, "uart_tx frame mark");
			else
				check_char(c, exp.chars[i-2], "uart_tx content character");
		end
	endtask

	task finish_loopback(input frame_t exp);
		tx_expect++;
		wait_done(1'b0, tx_expect, "tx_done");
		@(negedge sys_clk);
		check_level(tx_busy, 1'b0, "tx_busy after tx_done");
		check_level(tx_done, 1'b0, "tx_done one cycle wide");
		check_count(tx_done_cnt, tx_expect, "tx_done pulses");
		rx_expect++;
		wait_done(1'b1, rx_expect, "rx_done");
		check_count(rx_done_cnt, rx_expect, "rx_done pulses");
		check_frame(rx_frame, exp, "rx_frame");
	endtask

	// bad_idx marks the content byte sent with a low stop bit, -1 for none
	task drive_frame(input frame_t f, input int bad_idx);
		int i;
		send_byte(FRAME_MARK, 1'b1);
		send_byte(FRAME_MARK, 1'b1);
		for (i = 0; i < f.len; i++)
			send_byte(f.chars[i], i != bad_idx);
		send_byte(FRAME_MARK, 1'b1);
		send_byte(FRAME_MARK, 1'b1);
	endtask

	task expect_rx_idle(input string what);
		@(negedge sys_clk);
		check_count(rx_done_cnt, rx_expect, what);
		check_level(rx_busy, 1'b0, what);
	endtask

	initial begin
		frame_t f;
		frame_t exp_f;
		frame_t other;
		frame_t other_exp;
		int     i;

		sys_rst_n = 1'b0;
		tx_frame  = '0;
		tx_req    = 1'b0;
		drv_line  = 1'b1;
		loopback  = 1'b1;
		repeat (10) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		repeat (20) begin
			@(negedge sys_clk);
			check_level(uart_tx, 1'b1, "uart_tx after reset");
			check_level(tx_busy, 1'b0, "tx_busy after reset");
			check_level(tx_done, 1'b0, "tx_done after reset");
			check_level(rx_busy, 1'b0, "rx_busy after reset");
			check_level(rx_done, 1'b0, "rx_done after reset");
		end

		for (i = 0; i < N_FRAMES; i++) begin
			build_frame(xorshift32() % (MAX_CHARS + 1), f, exp_f);
			start_tx(f);
			expect_line_frame(exp_f);
			finish_loopback(exp_f);
		end

		@(posedge sys_clk);
		#1;
		loopback = 1'b0;

		// lone mark then a letter
		send_byte(FRAME_MARK, 1'b1);
		send_byte(8'h51, 1'b1);
		expect_rx_idle("rx after lone mark");
		// closing mark followed by a letter
		send_byte(FRAME_MARK, 1'b1);
		send_byte(FRAME_MARK, 1'b1);
		send_byte(8'h61, 1'b1);
		send_byte(8'h62, 1'b1);
		send_byte(FRAME_MARK, 1'b1);
		send_byte(8'h5a, 1'b1);
		expect_rx_idle("rx after broken closing mark");
		// one character too many, the overflow drops the frame
		send_byte(FRAME_MARK, 1'b1);
		send_byte(FRAME_MARK, 1'b1);
		for (i = 0; i <= MAX_CHARS; i++)
			send_byte(rand_char(), 1'b1);
		expect_rx_idle("rx after overlong content");

		build_frame(xorshift32() % (MAX_CHARS + 1), f, exp_f);
		drive_frame(f, -1);
		rx_expect++;
		wait_done(1'b1, rx_expect, "rx_done of driven frame");
		check_frame(rx_frame, exp_f, "rx_frame after malformed input");

		// low stop bit drops the frame, its closing marks then open a new one
		build_frame(6, f, exp_f);
		drive_frame(f, 2);
		@(negedge sys_clk);
		check_count(rx_done_cnt, rx_expect, "rx_done after stop error");
		check_level(rx_busy, 1'b1, "rx_busy after trailing marks");
		send_byte(8'hff, 1'b0);
		expect_rx_idle("rx after second stop error");
		build_frame(xorshift32() % (MAX_CHARS + 1), f, exp_f);
		drive_frame(f, -1);
		rx_expect++;
		wait_done(1'b1, rx_expect, "rx_done after stop error");
		check_frame(rx_frame, exp_f, "rx_frame after stop error");

		@(posedge sys_clk);
		#1;
		loopback = 1'b1;

		build_frame(1 + xorshift32() % MAX_CHARS, f, exp_f);
		build_frame(1 + xorshift32() % MAX_CHARS, other, other_exp);
		start_tx(f);
		fork
			begin
				repeat (3) @(negedge sys_clk);
				check_level(tx_busy, 1'b1, "tx_busy before second request");
				start_tx(other);
			end
			expect_line_frame(exp_f);
		join
		finish_loopback(exp_f);
		repeat (3 * 11 * CLKS_PER_BIT) begin
			@(negedge sys_clk);
			check_level(uart_tx, 1'b1, "uart_tx after ignored request");
		end
		check_count(tx_done_cnt, tx_expect, "tx_done after ignored request");
		check_count(rx_done_cnt, rx_expect, "rx_done after ignored request");

		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+testbench
logic/uart_frame_pkg.sv
logic/uart_tx_serializer.sv
logic/uart_rx_sampler.sv
logic/tx_framer.sv
logic/rx_deframer.sv
logic/uart_frame_link.sv
testbench/tb_uart_frame_link.sv

//--- Bender.yml
package:
  name: uart_frame_link

sources:
  - logic/uart_frame_pkg.sv
  - logic/uart_tx_serializer.sv
  - logic/uart_rx_sampler.sv
  - logic/tx_framer.sv
  - logic/rx_deframer.sv
  - logic/uart_frame_link.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_uart_frame_link.sv
